// File: run.sh
#!/bin/sh
# build and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -Mdir obj_dir \
    -f vlog.f > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_cpu > sim.log 2>&1
cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "FAIL"; exit 1; }
echo "PASS"
exit 0

// File: test/cpu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_asserts (
    input wire                              clk_i,
    input wire                              rst_n_i,
    input wire                              ir_we_i,     // fetch strobe
    input wire [cpu_isa_pkg::DATA_W-1:0]    mem_rdata_i,
    input wire [cpu_isa_pkg::ADDR_W-1:0]    mem_addr_i,
    input wire                              mem_oe_n_i,
    input wire                              mem_we_n_i
);

    import cpu_isa_pkg::*;

    logic ldi_fetch;   // LDI byte on the bus while fetching
    logic plain_fetch; // neither LDI nor jump group

    assign ldi_fetch   = ir_we_i & (mem_rdata_i[7:5] == {1'b1, KIND_LDI});
    assign plain_fetch = ir_we_i & ~ldi_fetch & (mem_rdata_i[7:5] != {1'b1, KIND_JMP});

    // idle bus in reset and on the first cycle out of it
    a_reset_idle: assert property (@(posedge clk_i)
        (!rst_n_i || $rose(rst_n_i)) |-> (mem_we_n_i && !mem_oe_n_i && mem_addr_i == '0))
        else $error("bus not idle around reset");

    a_we_oe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !mem_we_n_i |-> mem_oe_n_i) // never drive and read at once
        else $error("write strobe while output enable is low");

    a_oe_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_oe_n_i |-> !mem_we_n_i) // reads stop only for a write
        else $error("output enable high outside a write cycle");

    a_fetch_gap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ir_we_i |=> !ir_we_i)
        else $error("two fetches in a row");

    a_two_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ir_we_i && !ldi_fetch) |-> ##2 ir_we_i)
        else $error("instruction did not take two cycles");

    // straight line code steps by one byte
    a_plain_addr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        plain_fetch |-> ##2 (mem_addr_i == $past(mem_addr_i, 2) + 16'd1))
        else $error("fetch address did not advance by one");

    a_ldi_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ldi_fetch |-> ##2 !ir_we_i) // immediate byte, no fetch
        else $error("fetch during the immediate pair of LDI");

    a_ldi_four: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ldi_fetch |-> ##4 (ir_we_i && mem_addr_i == $past(mem_addr_i, 4) + 16'd2))
        else $error("LDI did not take four cycles and two bytes");

endmodule

bind cpu_core cpu_asserts u_asserts (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ir_we_i     (ir_we),
    .mem_rdata_i (mem_rdata_i),
    .mem_addr_i  (mem_addr_o),
    .mem_oe_n_i  (mem_oe_n_o),
    .mem_we_n_i  (mem_we_n_o)
);

`default_nettype wire

// File: test/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

    import cpu_isa_pkg::*;
    import cpu_alu_pkg::*;

    localparam logic [15:0] MARK_ADDR  = 16'hfff0; // last store of the program
    localparam logic [7:0]  MARK_DATA  = 8'h5a;
    localparam int          MAX_CYCLES = 20000;

    logic        clk;
    logic        rst_n;
    logic [7:0]  mem_rdata;
    logic [15:0] mem_addr;
    logic [7:0]  mem_wdata;
    logic        mem_oe_n;
    logic        mem_we_n;

    logic [7:0]  mem [65536];       // memory seen by the DUT
    logic [7:0]  model_mem [65536]; // golden model copy
    logic [7:0]  prog [$];
    string       name_at [int];     // test name per program byte
    string       cur_test;
    logic [15:0] exp_addr_q [$];    // expected stores in order
    logic [7:0]  exp_data_q [$];
    string       exp_name_q [$];
    logic        marker_seen;
    int          cycles;

    assign mem_rdata = mem[mem_addr]; // combinational read

    cpu_core UUT (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .mem_rdata_i (mem_rdata),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_oe_n_o  (mem_oe_n),
        .mem_we_n_o  (mem_we_n)
    );

    always #50 clk = ~clk;

    task automatic report_fail(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [15:0] exp, input logic [15:0] act);
        $display("Error: %s expected %h actual %h", name, exp, act);
        report_fail("memory write does not match the instruction model");
    endtask

    // write port, every store checked against the model
    always @(posedge clk) begin
        if (rst_n && !mem_we_n) begin
            if (exp_addr_q.size() == 0) begin
                report_fail("store seen after the last expected store");
            end else begin
                assert (mem_addr == exp_addr_q[0])
                    else report_value({exp_name_q[0], " addr"}, exp_addr_q[0], mem_addr);
                assert (mem_wdata == exp_data_q[0])
                    else report_value({exp_name_q[0], " data"}, 16'(exp_data_q[0]),
                                      16'(mem_wdata));
                mem[mem_addr] <= mem_wdata;
                if (mem_addr == MARK_ADDR) marker_seen = 1'b1;
                void'(exp_addr_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_name_q.pop_front());
            end
        end
    end

    // reference alu, returns {V, N, Z, C, result}
    function automatic logic [11:0] alu_ref(input logic [3:0] op, input logic [7:0] a,
                                            input logic [7:0] b, input logic cin);
        logic [8:0] w;
        logic       v;
        w = 9'd0;
        v = 1'b0;
        case (op)
            ADD, ADC: begin
                w = {1'b0, a} + {1'b0, b} + {8'd0, cin & (op == ADC)};
                v = (a[7] == b[7]) && (w[7] != a[7]);
            end
            SUB, SBC, CMP: begin
                w = {1'b0, a} - {1'b0, b} - {8'd0, cin & (op == SBC)}; // borrow in bit 8
                v = (a[7] != b[7]) && (w[7] != a[7]);
            end
            AND: w = {1'b0, a & b};
            OR:  w = {1'b0, a | b};
            XOR: w = {1'b0, a ^ b};
            NOT: w = {1'b0, ~b};
            MOV: w = {1'b0, b};
            INC: begin
                w = {1'b0, b} + 9'd1;
                v = (b == 8'h7f);
            end
            DEC: begin
                w = {1'b0, b} - 9'd1;
                v = (b == 8'h80);
            end
            SHL: w = {b, 1'b0};
            SHR: w = {b[0], 1'b0, b[7:1]};
            ROL: w = {b, cin};           // through carry
            ROR: w = {b[0], cin, b[7:1]};
            default: w = 9'd0;
        endcase
        return {v, w[7], (w[7:0] == 8'd0), w[8], w[7:0]};
    endfunction

    task automatic put(input logic [7:0] b);
        name_at[prog.size()] = cur_test;
        prog.push_back(b);
    endtask

    task automatic put_ldi(input logic [1:0] r, input logic [7:0] v);
        put({6'b110000, r});
        put(v);
    endtask

    // taken jump stores at s+5, not taken at s+6
    task automatic put_jump_test(input logic inv, input logic [1:0] f);
        logic [15:0] tgt;
        tgt = 16'(prog.size() + 6);
        put_ldi(REG_PH, tgt[15:8]);
        put_ldi(REG_PL, tgt[7:0]);
        put({3'b111, 1'b0, 1'b0, inv, f});
        put(8'h42); // MOV A, PL skipped when taken
        put(8'ha0); // ST A
    endtask

    task automatic build_program();
        logic [7:0] jx [3];
        logic [7:0] jy [3];
        jx = '{8'h00, 8'h00, 8'h80}; // Z, then C and N, then V
        jy = '{8'h00, 8'h01, 8'h01};
        cur_test = "ldi_st";
        repeat (4) begin
            put_ldi(REG_A, 8'($urandom()));
            put_ldi(REG_B, 8'($urandom()));
            put_ldi(REG_PL, 8'($urandom()));
            put_ldi(REG_PH, 8'h80 | 8'($urandom())); // keep clear of the code
            put(8'ha0);
            put(8'ha1);
        end
        cur_test = "ld";
        put_ldi(REG_PH, 8'h90);
        put_ldi(REG_PL, 8'($urandom()));
        put(8'h81); // LD B
        put(8'ha1);
        for (int op = 0; op < 16; op++) begin
            for (int dir = 0; dir < 2; dir++) begin
                cur_test = $sformatf("alu op %0d dir %0d", op, dir);
                put_ldi(REG_PH, 8'h81);
                put_ldi(REG_PL, 8'(op * 2 + dir));
                put_ldi(REG_A, 8'($urandom()));
                put_ldi(REG_B, 8'($urandom()));
                put({1'b0, 4'(op), 1'(dir), 2'd1});
                put(8'ha0);
                put(8'ha1);
            end
        end
        for (int s = 0; s < 3; s++) begin
            cur_test = $sformatf("jump set %0d", s);
            put_ldi(REG_A, jx[s]);
            put_ldi(REG_B, jy[s]);
            put(8'h79); // CMP B
            put(8'h41); // MOV A, B must keep the flags
            for (int f = 0; f < 4; f++) begin
                for (int i = 0; i < 2; i++) begin
                    cur_test = $sformatf("jump set %0d flag %0d inv %0d", s, f, i);
                    put_jump_test(1'(i), 2'(f));
                end
            end
        end
        cur_test = "marker";
        put_ldi(REG_PH, MARK_ADDR[15:8]);
        put_ldi(REG_PL, MARK_ADDR[7:0]);
        put_ldi(REG_A, MARK_DATA);
        put(8'ha0);
        repeat (4) put(NOP_BYTE);
    endtask

    task automatic load_memory();
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h3c; // pattern over the full address
        end
        foreach (prog[i]) mem[i] = prog[i];
        model_mem = mem;
    endtask

    // instruction level model, fills the expected store list
    task automatic run_model();
        logic [15:0] ip;
        logic [15:0] dp;
        logic [15:0] tmp;
        logic [7:0]  regs [4];
        logic [3:0]  flags;
        logic [7:0]  b;
        logic [7:0]  x;
        logic [7:0]  y;
        logic [1:0]  tgt;
        logic [11:0] fr;
        logic        done;
        int          steps;
        ip    = '0;
        dp    = '0;
        flags = '0;
        done  = 1'b0;
        steps = 0;
        for (int i = 0; i < 4; i++) regs[i] = '0;
        while (!done && steps < MAX_CYCLES) begin
            b = model_mem[ip];
            steps++;
            if (!b[7]) begin
                x   = b[2] ? regs[b[1:0]] : regs[REG_A];
                y   = b[2] ? regs[REG_A] : regs[b[1:0]];
                tgt = b[2] ? b[1:0] : 2'd0;
                fr  = alu_ref(b[6:3], x, y, flags[FLAG_C]);
                if (b[6:3] != CMP) begin
                    regs[tgt] = fr[7:0];
                    if (tgt[1]) dp = {regs[REG_PH], regs[REG_PL]};
                end
                if (b[6:3] != MOV) flags = fr[11:8];
                ip++;
            end else begin
                case (b[6:5])
                    KIND_LD: begin
                        regs[b[1:0]] = model_mem[dp];
                        if (b[1]) dp = {regs[REG_PH], regs[REG_PL]};
                        ip++;
                    end
                    KIND_ST: begin
                        model_mem[dp] = (b[1:0] == 2'd1) ? regs[REG_B] : regs[REG_A];
                        exp_addr_q.push_back(dp);
                        exp_data_q.push_back(model_mem[dp]);
                        exp_name_q.push_back(name_at[int'(ip)]);
                        if (dp == MARK_ADDR) done = 1'b1;
                        ip++;
                    end
                    KIND_LDI: begin
                        regs[b[1:0]] = model_mem[ip + 16'd1];
                        if (b[1]) dp = {regs[REG_PH], regs[REG_PL]};
                        ip = ip + 16'd2;
                    end
                    default: begin
                        if ((b[3] | flags[b[1:0]]) ^ b[2]) begin
                            tmp = dp; // old DP becomes IP
                            dp  = ip + 16'd1;
                            ip  = tmp;
                        end else begin
                            ip++;
                        end
                    end
                endcase
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        marker_seen = 1'b0;
        cycles      = 0;
        void'($urandom(32'h3293_b3ba));
        build_program();
        load_memory();
        run_model();
        repeat (16) @(posedge clk);
        #5 rst_n = 1'b1;
        while (!marker_seen && cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        #1;
        if (!marker_seen) begin
            report_fail("timeout waiting for the end marker store");
        end else if (exp_addr_q.size() != 0) begin
            report_fail("program ended with expected stores left over");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire                              clk_i,
    input  wire                              rst_n_i,
    input  wire [cpu_isa_pkg::DATA_W-1:0]    a_i,
    input  wire [cpu_isa_pkg::DATA_W-1:0]    b_i,
    input  wire cpu_alu_pkg::alu_op_e        op_i,
    input  wire                              flags_we_i,
    output logic [cpu_isa_pkg::DATA_W-1:0]   result_o,
    output logic [cpu_alu_pkg::FLAG_W-1:0]   flags_o
);

    import cpu_isa_pkg::*;
    import cpu_alu_pkg::*;

    logic [DATA_W:0]   wide;    // carry or borrow on top of the result
    logic              v;       // signed overflow
    logic              c_in;    // stored carry
    logic [FLAG_W-1:0] flags_q;

    assign c_in = flags_q[FLAG_C];

    always_comb begin
        wide = '0;
        v    = 1'b0;
        unique case (op_i)
            ADD: begin
                wide = {1'b0, a_i} + {1'b0, b_i};
                v    = (a_i[DATA_W-1] == b_i[DATA_W-1]) & (wide[DATA_W-1] != a_i[DATA_W-1]);
            end
            ADC: begin
                wide = {1'b0, a_i} + {1'b0, b_i} + {{DATA_W{1'b0}}, c_in};
                v    = (a_i[DATA_W-1] == b_i[DATA_W-1]) & (wide[DATA_W-1] != a_i[DATA_W-1]);
            end
            SUB, CMP: begin
                wide = {1'b0, a_i} - {1'b0, b_i}; // top bit set on borrow
                v    = (a_i[DATA_W-1] != b_i[DATA_W-1]) & (wide[DATA_W-1] != a_i[DATA_W-1]);
            end
            SBC: begin
                wide = {1'b0, a_i} - {1'b0, b_i} - {{DATA_W{1'b0}}, c_in};
                v    = (a_i[DATA_W-1] != b_i[DATA_W-1]) & (wide[DATA_W-1] != a_i[DATA_W-1]);
            end
            AND: wide = {1'b0, a_i & b_i};
            OR:  wide = {1'b0, a_i | b_i};
            XOR: wide = {1'b0, a_i ^ b_i};
            NOT: wide = {1'b0, ~b_i};
            MOV: wide = {1'b0, b_i};
            INC: begin
                wide = {1'b0, b_i} + {{DATA_W{1'b0}}, 1'b1};
                v    = ~b_i[DATA_W-1] & wide[DATA_W-1]; // 7f -> 80
            end
            DEC: begin
                wide = {1'b0, b_i} - {{DATA_W{1'b0}}, 1'b1};
                v    = b_i[DATA_W-1] & ~wide[DATA_W-1]; // 80 -> 7f
            end
            SHL: wide = {b_i, 1'b0};                       // msb into carry
            SHR: wide = {b_i[0], 1'b0, b_i[DATA_W-1:1]};   // lsb into carry
            ROL: wide = {b_i, c_in};
            ROR: wide = {b_i[0], c_in, b_i[DATA_W-1:1]};
        endcase
    end

    assign result_o = wide[DATA_W-1:0];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            flags_q <= '0;
        end else if (flags_we_i) begin
            flags_q[FLAG_C] <= wide[DATA_W];
            flags_q[FLAG_Z] <= ~|wide[DATA_W-1:0];
            flags_q[FLAG_N] <= wide[DATA_W-1];
            flags_q[FLAG_V] <= v;
        end
    end

    assign flags_o = flags_q;

endmodule

`default_nettype wire

// File: verilog/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  wire                              clk_i,
    input  wire                              rst_n_i,
    input  wire cpu_isa_pkg::instr_u         ir_i,
    input  wire [cpu_alu_pkg::FLAG_W-1:0]    flags_i,
    output logic                             ir_we_o,
    output logic                             inc_ip_o,
    output logic                             addr_dp_o,
    output logic                             swap_p_o,
    output logic                             dp_load_o,
    output logic                             mem_oe_n_o,
    output logic                             mem_we_n_o,
    output logic                             reg_we_o,
    output cpu_isa_pkg::reg_idx_e            reg_wr_idx_o,
    output logic                             reg_src_mem_o,
    output cpu_isa_pkg::reg_idx_e            alu_b_idx_o,
    output cpu_alu_pkg::alu_op_e             alu_op_o,
    output logic                             alu_to_a_o,
    output logic                             flags_we_o,
    output logic                             st_src_o
);

    import cpu_isa_pkg::*;
    import cpu_alu_pkg::*;

    logic     phase_q;   // low in fetch, high in execute
    logic     super_q;   // second pair of an LDI
    logic     dp_load_q; // DP picks up PL/PH one cycle after the write
    logic     is_alu;
    logic     is_ld;
    logic     is_st;
    logic     is_ldi;
    logic     is_jmp;
    logic     exec;      // execute phase
    logic     imm;       // immediate fetch of an LDI
    logic     cond;      // jump condition result
    logic     st_cycle;  // bus write cycle
    logic     alu_wr;    // alu result goes to a register
    alu_op_e  op;
    reg_idx_e rsel;

    // alu view
    assign is_alu = ~ir_i.alu.cls;
    assign op     = alu_op_e'(ir_i.alu.op);
    assign rsel   = ir_i.alu.rsel; // bits 1:0 name a register in every class

    // ctl view
    assign is_ld  = ir_i.ctl.cls & (ir_i.ctl.kind == KIND_LD);
    assign is_st  = ir_i.ctl.cls & (ir_i.ctl.kind == KIND_ST);
    assign is_ldi = ir_i.ctl.cls & (ir_i.ctl.kind == KIND_LDI);
    assign is_jmp = ir_i.ctl.cls & (ir_i.ctl.kind == KIND_JMP);

    // jmp_all forces the flag term high, inv then turns JMP into NOP
    assign cond = (ir_i.ctl.jmp_all | flags_i[ir_i.ctl.flag]) ^ ir_i.ctl.inv;

    // two phases per instruction, LDI runs the pair twice
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase_q   <= 1'b0;
            super_q   <= 1'b0;
            dp_load_q <= 1'b0;
        end else begin
            phase_q <= ~phase_q;
            if (phase_q) begin
                super_q <= is_ldi & ~super_q; // set after first LDI pair, cleared after second
            end
            dp_load_q <= reg_we_o & ((reg_wr_idx_o == REG_PL) | (reg_wr_idx_o == REG_PH));
        end
    end

    assign exec = phase_q;
    assign imm  = ~phase_q & super_q;

    // fetch only in phase 0 of the first pair
    assign ir_we_o  = ~phase_q & ~super_q;
    assign inc_ip_o = exec; // end of every phase 1

    // pointer strobes
    assign addr_dp_o = exec & (is_ld | is_st);
    assign swap_p_o  = exec & is_jmp & cond; // toggles at the same edge as inc
    assign dp_load_o = dp_load_q;

    // bus read everywhere except the ST execute cycle
    assign st_cycle   = exec & is_st;
    assign mem_oe_n_o = st_cycle;
    assign mem_we_n_o = ~st_cycle; // memory writes at the closing edge
    assign st_src_o   = (rsel == REG_B);

    // register writes from memory or from the alu
    assign reg_src_mem_o = (exec & is_ld) | (imm & is_ldi);
    assign alu_wr        = exec & is_alu & (op != CMP); // CMP keeps the registers
    assign reg_we_o      = reg_src_mem_o | alu_wr;
    assign reg_wr_idx_o  = (is_alu & ~ir_i.alu.dir) ? REG_A : rsel;

    // alu operand routing
    assign alu_to_a_o  = ~ir_i.alu.dir;
    assign alu_b_idx_o = rsel;
    assign alu_op_o    = op;
    assign flags_we_o  = exec & is_alu & (op != MOV);

endmodule

`default_nettype wire

// File: verilog/cpu_alu_pkg.sv
`default_nettype none

package cpu_alu_pkg;

    // op field of the alu format
    typedef enum logic [3:0] {
        ADD = 4'b0000,
        ADC = 4'b0001, // add with stored carry
        SUB = 4'b0010,
        SBC = 4'b0011, // subtract with stored borrow
        AND = 4'b0100,
        OR  = 4'b0101,
        XOR = 4'b0110,
        NOT = 4'b0111, // unary ops work on the b operand
        MOV = 4'b1000, // leaves the flags alone
        INC = 4'b1001,
        DEC = 4'b1010,
        SHL = 4'b1011,
        SHR = 4'b1100,
        ROL = 4'b1101, // rotate through carry
        ROR = 4'b1110,
        CMP = 4'b1111  // flags of a - b only
    } alu_op_e;

    localparam int FLAG_W = 4; // width of the flag word

    // bit positions inside the flag word
    localparam int FLAG_C = 0; // carry, borrow on subtract
    localparam int FLAG_Z = 1; // zero result
    localparam int FLAG_N = 2; // result msb
    localparam int FLAG_V = 3; // signed overflow

endpackage

`default_nettype wire

// File: verilog/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  wire                              clk_i,
    input  wire                              rst_n_i,
    input  wire [cpu_isa_pkg::DATA_W-1:0]    mem_rdata_i,
    output logic [cpu_isa_pkg::ADDR_W-1:0]   mem_addr_o,
    output logic [cpu_isa_pkg::DATA_W-1:0]   mem_wdata_o,
    output logic                             mem_oe_n_o,
    output logic                             mem_we_n_o
);

    import cpu_isa_pkg::*;
    import cpu_alu_pkg::*;

    instr_u            ir_q;        // current instruction
    logic              ir_we;
    logic              inc_ip;
    logic              addr_dp;
    logic              swap_p;
    logic              dp_load;
    logic              reg_we;
    logic              reg_src_mem; // memory data rather than alu result
    logic              alu_to_a;    // direction bit clear
    logic              flags_we;
    logic              st_src;
    reg_idx_e          reg_wr_idx;
    reg_idx_e          alu_b_idx;
    alu_op_e           alu_op;
    logic [FLAG_W-1:0] flags;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] rd_data;
    logic [DATA_W-1:0] pl;
    logic [DATA_W-1:0] ph;
    logic [DATA_W-1:0] alu_a;
    logic [DATA_W-1:0] alu_b;
    logic [DATA_W-1:0] alu_res;
    logic [DATA_W-1:0] reg_wdata;

    // instruction register, NOP after reset
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ir_q <= instr_u'(NOP_BYTE);
        end else if (ir_we) begin
            ir_q <= instr_u'(mem_rdata_i);
        end
    end

    // A = op(A, r) or r = op(r, A)
    assign alu_a = alu_to_a ? a : rd_data;
    assign alu_b = alu_to_a ? rd_data : a;

    assign reg_wdata = reg_src_mem ? mem_rdata_i : alu_res; // LD/LDI data or alu

    control_unit u_ctrl (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .ir_i          (ir_q),
        .flags_i       (flags),
        .ir_we_o       (ir_we),
        .inc_ip_o      (inc_ip),
        .addr_dp_o     (addr_dp),
        .swap_p_o      (swap_p),
        .dp_load_o     (dp_load),
        .mem_oe_n_o    (mem_oe_n_o),
        .mem_we_n_o    (mem_we_n_o),
        .reg_we_o      (reg_we),
        .reg_wr_idx_o  (reg_wr_idx),
        .reg_src_mem_o (reg_src_mem),
        .alu_b_idx_o   (alu_b_idx),
        .alu_op_o      (alu_op),
        .alu_to_a_o    (alu_to_a),
        .flags_we_o    (flags_we),
        .st_src_o      (st_src)
    );

    alu u_alu (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .a_i        (alu_a),
        .b_i        (alu_b),
        .op_i       (alu_op),
        .flags_we_i (flags_we),
        .result_o   (alu_res),
        .flags_o    (flags)
    );

    reg_file u_regs (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .we_i      (reg_we),
        .wr_idx_i  (reg_wr_idx),
        .wdata_i   (reg_wdata),
        .rd_idx_i  (alu_b_idx),
        .st_src_i  (st_src),
        .a_o       (a),
        .rd_data_o (rd_data),
        .st_data_o (mem_wdata_o),
        .pl_o      (pl),
        .ph_o      (ph)
    );

    pointer_unit u_ptr (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .inc_ip_i  (inc_ip),
        .swap_p_i  (swap_p),
        .addr_dp_i (addr_dp),
        .dp_load_i (dp_load),
        .pl_i      (pl),
        .ph_i      (ph),
        .addr_o    (mem_addr_o)
    );

endmodule

`default_nettype wire

// File: verilog/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

    localparam int ADDR_W = 16; // memory address bus
    localparam int DATA_W = 8;  // data bus and register width

    // register file slots
    typedef enum logic [1:0] {
        REG_A  = 2'd0, // accumulator
        REG_B  = 2'd1,
        REG_PL = 2'd2, // pointer low byte
        REG_PH = 2'd3  // pointer high byte
    } reg_idx_e;

    // ctl class kind codes in bits 6:5
    localparam logic [1:0] KIND_LD  = 2'b00; // [DP] -> r
    localparam logic [1:0] KIND_ST  = 2'b01; // A or B -> [DP]
    localparam logic [1:0] KIND_LDI = 2'b10; // IP++, [IP] -> r
    localparam logic [1:0] KIND_JMP = 2'b11; // Jc, JMP and NOP share this group

    // alu format 0 oooo d rr
    typedef struct packed {
        logic       cls;  // low for alu class
        logic [3:0] op;   // alu operation code
        logic       dir;  // set means result goes back to r
        reg_idx_e   rsel; // second operand, also target when dir set
    } alu_fmt_t;

    // memory and jump format 1 kk s j i ff
    typedef struct packed {
        logic       cls;     // high for ctl class
        logic [1:0] kind;    // one of the KIND_ codes
        logic       spare;
        logic       jmp_all; // ignore the flag
        logic       inv;     // invert the condition
        logic [1:0] flag;    // flag position to test
    } ctl_fmt_t;

    // same byte, two decodings picked by the class bit
    typedef union packed {
        alu_fmt_t alu;
        ctl_fmt_t ctl;
    } instr_u;

    // jump group with jmp_all and inv both set, never taken
    localparam logic [7:0] NOP_BYTE = 8'b1110_1100;

endpackage

`default_nettype wire

// File: verilog/pointer_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pointer_unit (
    input  wire                              clk_i,
    input  wire                              rst_n_i,
    input  wire                              inc_ip_i,
    input  wire                              swap_p_i,
    input  wire                              addr_dp_i,
    input  wire                              dp_load_i,
    input  wire [cpu_isa_pkg::DATA_W-1:0]    pl_i,
    input  wire [cpu_isa_pkg::DATA_W-1:0]    ph_i,
    output logic [cpu_isa_pkg::ADDR_W-1:0]   addr_o
);

    import cpu_isa_pkg::*;

    logic [ADDR_W-1:0] ptr_q [2]; // roles set by sel_q
    logic              sel_q;     // index of the pointer acting as IP
    logic [ADDR_W-1:0] ip;
    logic [ADDR_W-1:0] dp;

    assign ip = ptr_q[sel_q];
    assign dp = ptr_q[!sel_q];

    // inc and dp load never hit the same pointer, swap only flips roles
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr_q[0] <= '0;
            ptr_q[1] <= '0;
            sel_q    <= 1'b0;
        end else begin
            if (inc_ip_i) begin
                ptr_q[sel_q] <= ip + ADDR_W'(1); // old IP, even when swapping
            end
            if (dp_load_i) begin
                ptr_q[!sel_q] <= {ph_i, pl_i};
            end
            if (swap_p_i) begin
                sel_q <= ~sel_q; // incremented IP turns into DP
            end
        end
    end

    // address mux
    assign addr_o = addr_dp_i ? dp : ip;

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                              clk_i,
    input  wire                              rst_n_i,
    input  wire                              we_i,
    input  wire cpu_isa_pkg::reg_idx_e       wr_idx_i,
    input  wire [cpu_isa_pkg::DATA_W-1:0]    wdata_i,
    input  wire cpu_isa_pkg::reg_idx_e       rd_idx_i,
    input  wire                              st_src_i,
    output logic [cpu_isa_pkg::DATA_W-1:0]   a_o,
    output logic [cpu_isa_pkg::DATA_W-1:0]   rd_data_o,
    output logic [cpu_isa_pkg::DATA_W-1:0]   st_data_o,
    output logic [cpu_isa_pkg::DATA_W-1:0]   pl_o,
    output logic [cpu_isa_pkg::DATA_W-1:0]   ph_o
);

    import cpu_isa_pkg::*;

    logic [DATA_W-1:0] regs_q [4]; // A, B, PL, PH by reg_idx_e

    // single write port
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            regs_q[REG_A]  <= '0;
            regs_q[REG_B]  <= '0;
            regs_q[REG_PL] <= '0;
            regs_q[REG_PH] <= '0;
        end else if (we_i) begin
            regs_q[wr_idx_i] <= wdata_i;
        end
    end

    // accumulator always visible to the alu
    assign a_o = regs_q[REG_A];

    // selected alu operand
    assign rd_data_o = regs_q[rd_idx_i];

    // store source is A or B only
    assign st_data_o = st_src_i ? regs_q[REG_B] : regs_q[REG_A];

    // pointer bytes feed the DP load
    assign pl_o = regs_q[REG_PL];
    assign ph_o = regs_q[REG_PH];

endmodule

`default_nettype wire

// File: vlog.f
verilog/cpu_isa_pkg.sv
verilog/cpu_alu_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/pointer_unit.sv
verilog/control_unit.sv
verilog/cpu_core.sv
test/cpu_asserts.sv
test/tb_cpu.sv
